/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = itim_tb
FILELIST = sim.f

OBJ_DIR = obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)
SIM_LOG = sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST)) itim_params.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(SIM_LOG) 2>&1; status=$$?; cat $(SIM_LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(SIM_LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

/* fetch_pkg.sv */
package fetch_pkg;

  // back stage states
  typedef enum logic [1:0] {
    st_hit,
    st_miss,
    st_load,
    st_fence
  } fetch_state_e;

  // outcome of a decoded request
  typedef enum logic [2:0] {
    kind_none,
    kind_hit,
    kind_miss,
    kind_load,
    kind_clear
  } fetch_kind_e;

endpackage

/* itim.sv */
`timescale 1ns/1ns

`include "itim_params.svh"

module itim (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input logic [31:0] fetch_addr,
  output logic [63:0] fetch_rdata,
  output logic fetch_ready,
  output logic mem_valid,
  output logic [31:0] mem_addr,
  input logic [31:0] mem_rdata,
  input logic mem_ready
);

  // one interface per word bank
  itim_bank_if banks [`ITIM_WIDTH] ();

  for (genvar g = 0; g < `ITIM_WIDTH; g++) begin : g_bank
    itim_bank bank_i (
      .clock (clock),
      .port (banks[g])
    );
  end

  itim_ctrl ctrl_i (
    .clock (clock),
    .reset (reset),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr (fetch_addr),
    .fetch_rdata (fetch_rdata),
    .fetch_ready (fetch_ready),
    .mem_valid (mem_valid),
    .mem_addr (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .banks (banks)
  );

endmodule

/* itim_assert.sv */
`timescale 1ns/1ns

module itim_assert import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic fetch_ready,
  input logic mem_valid,
  input logic mem_ready,
  input logic [31:0] mem_addr,
  input fetch_state_e state,
  input fetch_kind_e kind
);

  // the first edge only loads the reset values
  logic reset_seen = 1'b0;

  always @(posedge clock) begin
    if (!reset) begin
      reset_seen <= 1'b1;
    end
  end

  ready_pulse: assert property (@(posedge clock) disable iff (!reset)
    fetch_ready |=> !fetch_ready)
    else $error("fetch_ready high for two cycles in a row");

  // address may only move in the cycle of a mem_ready
  addr_held: assert property (@(posedge clock) disable iff (!reset)
    (mem_valid && !mem_ready && $past(mem_valid && !mem_ready)) |-> $stable(mem_addr))
    else $error("mem_addr changed while a word was pending");

  hit_quiet: assert property (@(posedge clock) disable iff (!reset)
    (state == st_hit && kind == kind_hit) |=> !mem_valid)
    else $error("mem_valid raised right after a hit");

  reset_quiet: assert property (@(posedge clock)
    (!reset && reset_seen) |-> (!fetch_ready && !mem_valid))
    else $error("fetch_ready or mem_valid high during reset");

  hit_seen: cover property (@(posedge clock) kind == kind_hit);
  miss_seen: cover property (@(posedge clock) kind == kind_miss);
  load_seen: cover property (@(posedge clock) kind == kind_load);
  clear_seen: cover property (@(posedge clock) kind == kind_clear);

endmodule

bind itim itim_assert itim_assert_i (
  .clock (clock),
  .reset (reset),
  .fetch_ready (fetch_ready),
  .mem_valid (mem_valid),
  .mem_ready (mem_ready),
  .mem_addr (mem_addr),
  .state (ctrl_i.state),
  .kind (ctrl_i.kind)
);

/* itim_bank.sv */
`timescale 1ns/1ns

`include "itim_params.svh"

module itim_bank import itim_pkg::*; (
  input logic clock,
  itim_bank_if.bank port
);

  // starts out with every entry unlocked
  itim_entry_t entries [`ITIM_DEPTH] = '{default: '0};

  logic [`ITIM_INDEX_BITS-1:0] raddr_q;

  always_ff @(posedge clock) begin
    if (port.wen) begin
      entries[port.waddr] <= port.wdata;
    end
    raddr_q <= port.raddr;
  end

  // read sees a write from the same edge
  assign port.rdata = entries[raddr_q];

endmodule

/* itim_bank_if.sv */
`timescale 1ns/1ns

`include "itim_params.svh"

interface itim_bank_if import itim_pkg::*; ();

  logic wen;
  logic [`ITIM_INDEX_BITS-1:0] waddr;
  itim_entry_t wdata;
  logic [`ITIM_INDEX_BITS-1:0] raddr;
  itim_entry_t rdata;

  modport ctrl (
    output wen, waddr, wdata, raddr,
    input rdata
  );

  modport bank (
    input wen, waddr, wdata, raddr,
    output rdata
  );

endinterface

/* itim_ctrl.sv */
`timescale 1ns/1ns

`include "itim_params.svh"

module itim_ctrl import itim_pkg::*, fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input logic [31:0] fetch_addr,
  output logic [63:0] fetch_rdata,
  output logic fetch_ready,
  output logic mem_valid,
  output logic [31:0] mem_addr,
  input logic [31:0] mem_rdata,
  input logic mem_ready,
  itim_bank_if.ctrl banks [`ITIM_WIDTH]
);

  localparam logic [31:0] window = `ITIM_TOP_ADDR - `ITIM_BASE_ADDR;
  localparam logic [`ITIM_INDEX_BITS-1:0] last_index =
    `ITIM_INDEX_BITS'(`ITIM_DEPTH - 1);

  // front stage
  itim_addr_u req0;
  itim_addr_u req1;
  itim_addr_u rd0;
  itim_addr_u rd1;
  itim_addr_u f_addr0;
  itim_addr_u f_addr1;
  logic f_enable;
  logic f_fence;

  // back stage
  fetch_state_e state;
  fetch_state_e state_d;
  fetch_kind_e kind;
  logic incr;
  logic incr_d;
  logic [`ITIM_INDEX_BITS-1:0] sweep;
  logic [`ITIM_INDEX_BITS-1:0] sweep_d;
  logic sweep_done;
  logic sweep_done_d;
  logic lock0;
  logic lock1;
  logic [31:0] low_word;
  logic [31:0] low_d;
  logic [31:0] off0;
  logic [31:0] off1;
  logic outside;

  // bank side
  itim_entry_t entry_a [`ITIM_WIDTH];
  itim_entry_t entry0;
  itim_entry_t entry1;
  logic wr_one;
  logic wr_all;
  logic [`ITIM_WORD_BITS-1:0] wr_word;
  logic [`ITIM_INDEX_BITS-1:0] wr_index;
  itim_entry_t wr_entry;

  assign req0.raw = fetch_addr;
  assign req1.raw = fetch_addr + 32'd4;

  // banks are addressed straight from the request so data is there at decode
  assign rd0 = fetch_valid ? req0 : f_addr0;
  assign rd1 = fetch_valid ? req1 : f_addr1;

  for (genvar g = 0; g < `ITIM_WIDTH; g++) begin : g_bank
    assign entry_a[g] = banks[g].rdata;
    assign banks[g].raddr = (rd1.fields.word == `ITIM_WORD_BITS'(g)) ?
                            rd1.fields.index : rd0.fields.index;
    assign banks[g].wen = wr_all || (wr_one && wr_word == `ITIM_WORD_BITS'(g));
    assign banks[g].waddr = wr_index;
    assign banks[g].wdata = wr_entry;
  end

  assign entry0 = entry_a[f_addr0.fields.word];
  assign entry1 = entry_a[f_addr1.fields.word];

  // offsets wrap for addresses below the base
  assign off0 = f_addr0.raw - `ITIM_BASE_ADDR;
  assign off1 = f_addr1.raw - `ITIM_BASE_ADDR;
  assign outside = (off0 >= window) || (off1 >= window);

  always_comb begin
    kind = kind_none;
    state_d = state;
    incr_d = incr;
    sweep_d = sweep;
    sweep_done_d = sweep_done;
    low_d = low_word;
    fetch_ready = 1'b0;
    fetch_rdata = '0;
    mem_valid = 1'b0;
    mem_addr = f_addr0.raw;
    wr_one = 1'b0;
    wr_all = 1'b0;
    wr_word = f_addr0.fields.word;
    wr_index = f_addr0.fields.index;
    wr_entry = '0;
    case (state)
      st_hit: begin
        if (f_enable) begin
          if (f_fence) begin
            kind = kind_clear;
          end else if (outside) begin
            kind = kind_load;
          end else if (!entry0.lock || !entry1.lock) begin
            kind = kind_miss;
          end else if (entry0.tag != f_addr0.fields.tag ||
                       entry1.tag != f_addr1.fields.tag) begin
            kind = kind_load;
          end else begin
            kind = kind_hit;
          end
        end
        case (kind)
          kind_hit: begin
            fetch_ready = 1'b1;
            fetch_rdata = {entry1.data, entry0.data};
          end
          kind_miss: begin
            state_d = st_miss;
            mem_valid = 1'b1;
            incr_d = 1'b0;
          end
          kind_load: begin
            state_d = st_load;
            mem_valid = 1'b1;
            incr_d = 1'b0;
          end
          kind_clear: begin
            state_d = st_fence;
            sweep_d = '0;
            sweep_done_d = 1'b0;
          end
          default: begin
          end
        endcase
      end
      st_miss, st_load: begin
        mem_valid = 1'b1;
        mem_addr = incr ? f_addr1.raw : f_addr0.raw;
        if (mem_ready && !incr) begin
          // second word is requested from this cycle on
          mem_addr = f_addr1.raw;
          incr_d = 1'b1;
          low_d = mem_rdata;
          wr_one = (state == st_miss) && !lock0;
          wr_entry = '{lock: 1'b1, tag: f_addr0.fields.tag, data: mem_rdata};
        end else if (mem_ready) begin
          mem_valid = 1'b0;
          fetch_ready = 1'b1;
          fetch_rdata = {mem_rdata, low_word};
          state_d = st_hit;
          incr_d = 1'b0;
          wr_one = (state == st_miss) && !lock1;
          wr_word = f_addr1.fields.word;
          wr_index = f_addr1.fields.index;
          wr_entry = '{lock: 1'b1, tag: f_addr1.fields.tag, data: mem_rdata};
        end
      end
      st_fence: begin
        if (sweep_done) begin
          fetch_ready = 1'b1;
          state_d = st_hit;
          sweep_done_d = 1'b0;
        end else begin
          // one index of every bank per cycle
          wr_all = 1'b1;
          wr_index = sweep;
          sweep_d = sweep + 1'b1;
          if (sweep == last_index) begin
            sweep_done_d = 1'b1;
          end
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      f_enable <= 1'b0;
      f_fence <= 1'b0;
      state <= st_hit;
      incr <= 1'b0;
      sweep <= '0;
      sweep_done <= 1'b0;
    end else begin
      f_enable <= fetch_valid;
      f_fence <= fetch_fence;
      state <= state_d;
      incr <= incr_d;
      sweep <= sweep_d;
      sweep_done <= sweep_done_d;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      f_addr0 <= req0;
      f_addr1 <= req1;
    end
    // locks as seen at decode decide which words a miss may write
    if (state == st_hit && f_enable) begin
      lock0 <= entry0.lock;
      lock1 <= entry1.lock;
    end
    low_word <= low_d;
  end

endmodule

/* itim_params.svh */
`ifndef ITIM_PARAMS_SVH
`define ITIM_PARAMS_SVH

// bank geometry
`define ITIM_DEPTH 16
`define ITIM_WIDTH 4
`define ITIM_INDEX_BITS 4
`define ITIM_WORD_BITS 2

// tag covers what is left of the word address
`define ITIM_TAG_BITS (30 - `ITIM_INDEX_BITS - `ITIM_WORD_BITS)

// address window, top is exclusive
`define ITIM_BASE_ADDR 32'h0000_0000
`define ITIM_TOP_ADDR 32'h0000_1000

`endif

/* itim_pkg.sv */
package itim_pkg;

`include "itim_params.svh"

  // fetch address split into its ITIM fields
  typedef struct packed {
    logic [`ITIM_TAG_BITS-1:0] tag;
    logic [`ITIM_INDEX_BITS-1:0] index;
    logic [`ITIM_WORD_BITS-1:0] word;
    logic [1:0] offset;
  } itim_fields_t;

  // same 32 bits, seen as a plain word or as fields
  typedef union packed {
    logic [31:0] raw;
    itim_fields_t fields;
  } itim_addr_u;

  // one stored word, lock marks it as valid
  typedef struct packed {
    logic lock;
    logic [`ITIM_TAG_BITS-1:0] tag;
    logic [31:0] data;
  } itim_entry_t;

endpackage

/* itim_tb.sv */
`timescale 1ns/1ns

`include "itim_params.svh"

module itim_tb import itim_pkg::*; ();

  localparam int random_pairs = 12;
  localparam int row_count = 12 + 2 * random_pairs;
  localparam int wait_limit = 2 * 4 + `ITIM_DEPTH + 10;
  // reset cycles on top
  localparam int cycle_limit = row_count * wait_limit + 5;

  logic clock;
  logic reset;
  logic fetch_valid;
  logic fetch_fence;
  logic [31:0] fetch_addr;
  logic [63:0] fetch_rdata;
  logic fetch_ready;
  logic mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_rdata = 32'd0;
  logic mem_ready = 1'b0;

  integer seed = 32'h1a97_a343;

  // stimulus table, one entry per test
  string names [row_count];
  logic fences [row_count];
  logic [31:0] addrs [row_count];
  logic from_mems [row_count];
  logic [63:0] datas [row_count];
  int rows_added = 0;

  // lock state the ITIM should hold after each row
  logic shadow_lock [`ITIM_WIDTH][`ITIM_DEPTH];
  logic [`ITIM_TAG_BITS-1:0] shadow_tag [`ITIM_WIDTH][`ITIM_DEPTH];

  int error_count = 0;
  int failed_tests = 0;
  int mem_requests = 0;
  int cycles = 0;
  logic mem_busy = 1'b0;
  int wait_left = 0;
  logic [31:0] mem_latched = 32'd0;

  itim itim_i (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'h5a5a_0000;
  endfunction

  function automatic logic predict_from_mem(input logic fence, input logic [31:0] addr);
    itim_addr_u a0;
    itim_addr_u a1;
    logic lock0;
    logic lock1;
    a0.raw = addr;
    a1.raw = addr + 32'd4;
    if (fence) begin
      for (int w = 0; w < `ITIM_WIDTH; w++) begin
        for (int i = 0; i < `ITIM_DEPTH; i++) begin
          shadow_lock[w][i] = 1'b0;
        end
      end
      return 1'b0;
    end
    if (!(a0.raw inside {[`ITIM_BASE_ADDR:`ITIM_TOP_ADDR - 1]}) ||
        !(a1.raw inside {[`ITIM_BASE_ADDR:`ITIM_TOP_ADDR - 1]})) begin
      return 1'b1;
    end
    lock0 = shadow_lock[a0.fields.word][a0.fields.index];
    lock1 = shadow_lock[a1.fields.word][a1.fields.index];
    // a miss fills only free entries and never a locked one
    if (!lock0 || !lock1) begin
      if (!lock0) begin
        shadow_lock[a0.fields.word][a0.fields.index] = 1'b1;
        shadow_tag[a0.fields.word][a0.fields.index] = a0.fields.tag;
      end
      if (!lock1) begin
        shadow_lock[a1.fields.word][a1.fields.index] = 1'b1;
        shadow_tag[a1.fields.word][a1.fields.index] = a1.fields.tag;
      end
      return 1'b1;
    end
    return shadow_tag[a0.fields.word][a0.fields.index] != a0.fields.tag ||
           shadow_tag[a1.fields.word][a1.fields.index] != a1.fields.tag;
  endfunction

  task automatic add_row(input string name, input logic fence, input logic [31:0] addr,
                         input logic from_mem, input logic use_model);
    logic predicted;
    predicted = predict_from_mem(fence, addr);
    names[rows_added] = name;
    fences[rows_added] = fence;
    addrs[rows_added] = addr;
    from_mems[rows_added] = use_model ? predicted : from_mem;
    datas[rows_added] = fence ? 64'd0 : {mem_word(addr + 32'd4), mem_word(addr)};
    rows_added++;
  endtask

  task automatic build_table();
    logic [31:0] addr;
    void'(predict_from_mem(1'b1, 32'd0));
    add_row("miss_100", 1'b0, 32'h100, 1'b1, 1'b0);
    add_row("hit_100", 1'b0, 32'h100, 1'b0, 1'b0);
    add_row("outside_2000", 1'b0, 32'h2000, 1'b1, 1'b0);
    add_row("outside_2000_again", 1'b0, 32'h2000, 1'b1, 1'b0);
    add_row("conflict_1100", 1'b0, 32'h1100, 1'b1, 1'b0);
    add_row("conflict_200", 1'b0, 32'h200, 1'b1, 1'b0);
    add_row("refetch_100", 1'b0, 32'h100, 1'b0, 1'b0);
    add_row("wrap_10c", 1'b0, 32'h10c, 1'b1, 1'b0);
    add_row("after_wrap_110", 1'b0, 32'h110, 1'b1, 1'b0);
    add_row("wrap_10c_again", 1'b0, 32'h10c, 1'b0, 1'b0);
    add_row("fence", 1'b1, 32'h0, 1'b0, 1'b0);
    add_row("after_fence_100", 1'b0, 32'h100, 1'b1, 1'b0);
    for (int r = 0; r < random_pairs; r++) begin
      addr = $random(seed);
      addr = `ITIM_BASE_ADDR + (addr % (`ITIM_TOP_ADDR - `ITIM_BASE_ADDR));
      addr[1:0] = 2'b00;
      add_row($sformatf("random_%0d_first", r), 1'b0, addr, 1'b0, 1'b1);
      add_row($sformatf("random_%0d_second", r), 1'b0, addr, 1'b0, 1'b1);
    end
  endtask

  task automatic check(input string name, input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s (%s): expected 0x%0h, actual 0x%0h",
               name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic run_row(input int r);
    int latency;
    int start_requests;
    int errors_before;
    logic seen;
    logic [63:0] data;
    errors_before = error_count;
    @(negedge clock);
    fetch_valid = 1'b1;
    fetch_fence = fences[r];
    fetch_addr = addrs[r];
    start_requests = mem_requests;
    @(posedge clock);
    @(negedge clock);
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    latency = 0;
    seen = 1'b0;
    data = '0;
    while (!seen && latency < wait_limit) begin
      @(posedge clock);
      latency++;
      if (fetch_ready) begin
        seen = 1'b1;
        data = fetch_rdata;
      end
    end
    if (!seen) begin
      $display("test %s got no fetch_ready within %0d cycles", names[r], wait_limit);
      error_count++;
    end else begin
      check(names[r], "data", datas[r], data);
      check(names[r], "memory requests", from_mems[r] ? 64'd2 : 64'd0,
            64'(mem_requests - start_requests));
      if (!from_mems[r]) begin
        check(names[r], "latency", fences[r] ? 64'(`ITIM_DEPTH + 2) : 64'd1, 64'(latency));
      end
    end
    if (error_count != errors_before) begin
      failed_tests++;
    end
    $display("test %0d %s: %s", r, names[r], error_count == errors_before ? "ok" : "FAILED");
  endtask

  // backing memory, one word per request after a random wait
  always @(negedge clock) begin
    if (mem_ready) begin
      mem_ready = 1'b0;
      mem_rdata = 32'd0;
    end else if (mem_busy) begin
      wait_left--;
      if (wait_left == 0) begin
        mem_rdata = mem_word(mem_latched);
        mem_ready = 1'b1;
        mem_busy = 1'b0;
      end
    end else if (mem_valid) begin
      mem_latched = mem_addr;
      wait_left = 1 + ($random(seed) & 3);
      mem_busy = 1'b1;
      mem_requests++;
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_addr = 32'd0;
    build_table();
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    for (int r = 0; r < row_count; r++) begin
      run_row(r);
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             row_count, row_count - failed_tests, failed_tests, error_count);
    if (failed_tests == 0 && error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
itim_pkg.sv
fetch_pkg.sv
itim_bank_if.sv
itim_bank.sv
itim_ctrl.sv
itim.sv
itim_assert.sv
itim_tb.sv
